// ==== all.f ====
hw/vec_cfg_pkg.sv
hw/vec_op_pkg.sv
hw/vec_regfile.sv
hw/vec_lane_alu.sv
hw/vec_sequencer.sv
hw/vec_unit_top.sv
tests/vec_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the vector unit testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f all.f --top-module vec_unit_tb -o sim_vec_unit

# a fatal stop still leaves its log for the search below
./obj_dir/sim_vec_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== tests/vec_unit_tb.sv ====
`timescale 1ns/1ps

module vec_unit_tb;

    // one table row, the instruction plus a stray strobe while busy
    typedef struct packed {
        vec_op_pkg::vec_instr_t instr;
        logic                   intrude;
    } step_t;

    logic                                 clk;
    logic                                 reset;
    logic                                 instr_valid;
    vec_op_pkg::vec_instr_t               instr;
    logic                                 host_we;
    vec_op_pkg::host_wr_t                 host_wr;
    logic                                 busy;
    logic                                 done;
    logic                                 st_valid;
    logic [vec_cfg_pkg::data_width-1:0]   st_data;

    // shadow copy of every vector, [vector][chunk]
    logic [63:0] model [1 << vec_cfg_pkg::addr_width][vec_cfg_pkg::chunks_per_vec];
    step_t       steps [$];
    integer      seed;

    vec_unit_top uut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .host_we     (host_we),
        .host_wr     (host_wr),
        .busy        (busy),
        .done        (done),
        .st_valid    (st_valid),
        .st_data     (st_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // lane rule on 8-bit elements, add and sub wrap
    function automatic logic [7:0] lane_rule(input vec_op_pkg::vec_opcode_e op,
                                             input logic [7:0] x, input logic [7:0] y);
        case (op)
            vec_op_pkg::op_vadd: return x + y;
            vec_op_pkg::op_vsub: return x - y;
            vec_op_pkg::op_vand: return x & y;
            vec_op_pkg::op_vor:  return x | y;
            vec_op_pkg::op_vxor: return x ^ y;
            default:             return x;
        endcase
    endfunction

    // one host write, lands at the edge after it is driven
    task automatic host_write(input logic [7:0] be, input int addr, input int off,
                              input logic [63:0] data);
        @(posedge clk);
        host_we      <= 1'b1;
        host_wr.be   <= be;
        host_wr.addr <= 3'(addr);
        host_wr.off  <= 2'(off);
        host_wr.data <= data;
        for (int j = 0; j < vec_cfg_pkg::dw_b; j++) begin
            if (be[j]) model[addr][off][j*8 +: 8] = data[j*8 +: 8];
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic add_step(input vec_op_pkg::vec_opcode_e op, input int vd, input int vs1,
                            input int vs2, input logic [7:0] mask, input logic intrude);
        step_t s;
        s.instr.opcode    = op;
        s.instr.vd        = 3'(vd);
        s.instr.vs1       = 3'(vs1);
        s.instr.vs2       = 3'(vs2);
        s.instr.byte_mask = mask;
        s.intrude         = intrude;
        steps.push_back(s);
    endtask

    task automatic run_step(input int idx);
        step_t                  s;
        vec_op_pkg::vec_instr_t ins;
        vec_op_pkg::vec_instr_t junk;
        vec_op_pkg::host_wr_t   junk_wr;
        logic [63:0]            exp_chunks [vec_cfg_pkg::chunks_per_vec];
        logic [63:0]            res [vec_cfg_pkg::chunks_per_vec];
        logic                   is_store;
        logic                   seen_done;
        int                     cycles;
        int                     st_cnt;
        s        = steps[idx];
        ins      = s.instr;
        is_store = (ins.opcode == vec_op_pkg::op_vstore);
        // stray work that must be dropped while busy
        junk     = '{vec_op_pkg::op_vadd, 3'd0, 3'd1, 3'd2, 8'hff};
        junk_wr  = '{8'hff, 3'd1, 2'd0, 64'h0123_4567_89ab_cdef};
        for (int k = 0; k < vec_cfg_pkg::chunks_per_vec; k++) exp_chunks[k] = model[ins.vs1][k];
        cycles    = 0;
        st_cnt    = 0;
        seen_done = 1'b0;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        // accepting edge, counting starts after it
        @(posedge clk);
        instr_valid <= 1'b0;
        while (!seen_done) begin
            @(negedge clk);
            cycles++;
            check_equal(64'(busy), 64'd1, $sformatf("step %0d busy before done", idx));
            if (st_valid) begin
                check_equal(64'(st_cnt < 4), 64'd1, "at most four store strobes");
                check_equal(64'(cycles), 64'(st_cnt + 2), "store strobe timing");
                check_equal(st_data, exp_chunks[st_cnt],
                            $sformatf("step %0d store chunk %0d", idx, st_cnt));
                st_cnt++;
            end
            if (done) begin
                seen_done = 1'b1;
            end else if (cycles >= 20) begin
                $display("timeout: step %0d never raised done", idx);
                $display("TEST FAIL");
                $fatal(1, "wait for done timed out");
            end else begin
                @(posedge clk);
                if (s.intrude && cycles == 2) begin
                    instr_valid <= 1'b1;
                    instr       <= junk;
                    host_we     <= 1'b1;
                    host_wr     <= junk_wr;
                end else begin
                    instr_valid <= 1'b0;
                    host_we     <= 1'b0;
                end
            end
        end
        check_equal(64'(cycles), is_store ? 64'd6 : 64'd7, "cycles from accept to done");
        check_equal(64'(st_cnt), is_store ? 64'd4 : 64'd0, "store strobe count");
        // every chunk is computed from the old values, so vd may alias a source
        if (!is_store) begin
            for (int k = 0; k < vec_cfg_pkg::chunks_per_vec; k++) begin
                for (int j = 0; j < vec_cfg_pkg::dw_b; j++) begin
                    res[k][j*8 +: 8] = ins.byte_mask[j] ?
                        lane_rule(ins.opcode, model[ins.vs1][k][j*8 +: 8],
                                  model[ins.vs2][k][j*8 +: 8]) :
                        model[ins.vd][k][j*8 +: 8];
                end
            end
            for (int k = 0; k < vec_cfg_pkg::chunks_per_vec; k++) model[ins.vd][k] = res[k];
        end
        // done is a single pulse and busy drops with it
        @(negedge clk);
        check_equal(64'(busy), 64'd0, "busy after done");
        check_equal(64'(done), 64'd0, "done is one cycle");
    endtask

    initial begin
        logic [63:0] d;
        logic [31:0] r;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        host_we     = 1'b0;
        host_wr     = '0;
        seed        = 32'h28199741;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_equal(64'(busy), 64'd0, "busy after reset");
        check_equal(64'(done), 64'd0, "done after reset");
        check_equal(64'(st_valid), 64'd0, "st_valid after reset");
        // full preload of vectors 0 to 5
        for (int a = 0; a < 6; a++) begin
            for (int o = 0; o < vec_cfg_pkg::chunks_per_vec; o++) begin
                d = {$random(seed), $random(seed)};
                host_write(8'hff, a, o, d);
            end
        end
        // partial byte enables on vectors 0 and 1
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            d = {$random(seed), $random(seed)};
            host_write(r[7:0], i % 2, i % 4, d);
        end
        add_step(vec_op_pkg::op_vstore, 0, 0, 0, 8'h00, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 1, 0, 8'h00, 1'b0);
        add_step(vec_op_pkg::op_vadd,   6, 0, 1, 8'hff, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 6, 0, 8'h00, 1'b0);
        add_step(vec_op_pkg::op_vsub,   7, 2, 3, 8'hff, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 7, 0, 8'h00, 1'b0);
        add_step(vec_op_pkg::op_vand,   6, 4, 5, 8'hff, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 6, 0, 8'h00, 1'b0);
        add_step(vec_op_pkg::op_vor,    7, 0, 5, 8'hff, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 7, 0, 8'h00, 1'b0);
        add_step(vec_op_pkg::op_vxor,   6, 1, 2, 8'hff, 1'b1);
        add_step(vec_op_pkg::op_vstore, 0, 6, 0, 8'h00, 1'b1);
        // partial mask keeps the old bytes of vd
        add_step(vec_op_pkg::op_vadd,   2, 3, 4, 8'h5a, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 2, 0, 8'h00, 1'b0);
        // in place, vd equals vs1
        add_step(vec_op_pkg::op_vsub,   3, 3, 1, 8'hff, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 3, 0, 8'h00, 1'b0);
        add_step(vec_op_pkg::op_vxor,   4, 4, 5, 8'hc3, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 4, 0, 8'h00, 1'b0);
        // stray writes to v0 and v1 must not have landed
        add_step(vec_op_pkg::op_vstore, 0, 0, 0, 8'h00, 1'b0);
        add_step(vec_op_pkg::op_vstore, 0, 1, 0, 8'h00, 1'b0);
        foreach (steps[i]) run_step(i);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== hw/vec_unit_top.sv ====
`timescale 1ns/1ps

module vec_unit_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 instr_valid,
    input  vec_op_pkg::vec_instr_t               instr,
    input  logic                                 host_we,
    input  vec_op_pkg::host_wr_t                 host_wr,
    output logic                                 busy,
    output logic                                 done,
    output logic                                 st_valid,
    output logic [vec_cfg_pkg::data_width-1:0]   st_data
);

    // sequencer to register file
    logic [vec_cfg_pkg::dw_b-1:0]       rd_en_1;
    logic [vec_cfg_pkg::dw_b-1:0]       rd_en_2;
    logic [vec_cfg_pkg::dw_b-1:0]       st_en;
    logic [vec_cfg_pkg::dw_b-1:0]       wb_en;
    logic [vec_cfg_pkg::addr_width-1:0] rd_addr_1;
    logic [vec_cfg_pkg::addr_width-1:0] rd_addr_2;
    logic [vec_cfg_pkg::addr_width-1:0] st_addr;
    logic [vec_cfg_pkg::addr_width-1:0] wb_addr;
    logic [vec_cfg_pkg::off_bits-1:0]   rd_off_1;
    logic [vec_cfg_pkg::off_bits-1:0]   rd_off_2;
    logic [vec_cfg_pkg::off_bits-1:0]   st_off;
    logic [vec_cfg_pkg::off_bits-1:0]   wb_off;

    // alu side
    vec_op_pkg::vec_opcode_e              alu_opcode;
    logic                                 op_valid;
    logic [vec_cfg_pkg::data_width-1:0]   rd_data_1;
    logic [vec_cfg_pkg::data_width-1:0]   rd_data_2;
    logic [vec_cfg_pkg::data_width-1:0]   alu_result;

    // muxed register file write port
    logic [vec_cfg_pkg::dw_b-1:0]         wr_en;
    logic [vec_cfg_pkg::addr_width-1:0]   wr_addr;
    logic [vec_cfg_pkg::off_bits-1:0]     wr_off;
    logic [vec_cfg_pkg::data_width-1:0]   wr_data;
    logic                                 host_sel;

    // host preload only while idle
    assign host_sel = host_we & ~busy;

    // write-back has priority, host gets the port otherwise
    always_comb begin
        if (|wb_en) begin
            wr_en   = wb_en;
            wr_addr = wb_addr;
            wr_off  = wb_off;
            wr_data = alu_result;
        end else begin
            wr_en   = host_sel ? host_wr.be : '0;
            wr_addr = host_wr.addr;
            wr_off  = host_wr.off;
            wr_data = host_wr.data;
        end
    end

    vec_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .done        (done),
        .rd_en_1     (rd_en_1),
        .rd_en_2     (rd_en_2),
        .st_en       (st_en),
        .wb_en       (wb_en),
        .rd_addr_1   (rd_addr_1),
        .rd_addr_2   (rd_addr_2),
        .st_addr     (st_addr),
        .wb_addr     (wb_addr),
        .rd_off_1    (rd_off_1),
        .rd_off_2    (rd_off_2),
        .st_off      (st_off),
        .wb_off      (wb_off),
        .alu_opcode  (alu_opcode),
        .op_valid    (op_valid),
        .st_valid    (st_valid)
    );

    vec_regfile u_rf (
        .clk       (clk),
        .rd_en_1   (rd_en_1),
        .rd_en_2   (rd_en_2),
        .wr_en     (wr_en),
        .st_en     (st_en),
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .wr_addr   (wr_addr),
        .st_addr   (st_addr),
        .rd_off_1  (rd_off_1),
        .rd_off_2  (rd_off_2),
        .wr_off    (wr_off),
        .st_off    (st_off),
        .wr_data   (wr_data),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .st_data   (st_data)
    );

    vec_lane_alu u_alu (
        .clk      (clk),
        .op_valid (op_valid),
        .opcode   (alu_opcode),
        .a        (rd_data_1),
        .b        (rd_data_2),
        .result   (alu_result)
    );

endmodule

// ==== hw/vec_sequencer.sv ====
`timescale 1ns/1ps

module vec_sequencer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 instr_valid,
    input  vec_op_pkg::vec_instr_t               instr,
    output logic                                 busy,
    output logic                                 done,
    output logic [vec_cfg_pkg::dw_b-1:0]         rd_en_1,
    output logic [vec_cfg_pkg::dw_b-1:0]         rd_en_2,
    output logic [vec_cfg_pkg::dw_b-1:0]         st_en,
    output logic [vec_cfg_pkg::dw_b-1:0]         wb_en,
    output logic [vec_cfg_pkg::addr_width-1:0]   rd_addr_1,
    output logic [vec_cfg_pkg::addr_width-1:0]   rd_addr_2,
    output logic [vec_cfg_pkg::addr_width-1:0]   st_addr,
    output logic [vec_cfg_pkg::addr_width-1:0]   wb_addr,
    output logic [vec_cfg_pkg::off_bits-1:0]     rd_off_1,
    output logic [vec_cfg_pkg::off_bits-1:0]     rd_off_2,
    output logic [vec_cfg_pkg::off_bits-1:0]     st_off,
    output logic [vec_cfg_pkg::off_bits-1:0]     wb_off,
    output vec_op_pkg::vec_opcode_e              alu_opcode,
    output logic                                 op_valid,
    output logic                                 st_valid
);

    // one chunk in flight, tagged with its own offset
    typedef struct packed {
        logic                                valid;
        logic [vec_cfg_pkg::off_bits-1:0]    off;
    } stage_t;

    vec_op_pkg::seq_state_e state;
    vec_op_pkg::vec_instr_t instr_r;

    // issue side of the chunk walk
    logic                             issuing;
    logic [vec_cfg_pkg::off_bits-1:0] issue_off;

    // rd_stage lines up with registered read data, alu_stage with the alu result
    stage_t rd_stage;
    stage_t alu_stage;

    logic is_store;
    logic last_retire;

    assign is_store = (instr_r.opcode == vec_op_pkg::op_vstore);
    assign busy     = (state == vec_op_pkg::st_run);

    // vstore retires when its last chunk leaves the store port,
    // alu ops when their last chunk is written back
    assign last_retire =
        (st_valid & (int'(rd_stage.off) == vec_cfg_pkg::chunks_per_vec - 1)) |
        (alu_stage.valid & (int'(alu_stage.off) == vec_cfg_pkg::chunks_per_vec - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= vec_op_pkg::st_idle;
            issuing   <= 1'b0;
            issue_off <= '0;
            rd_stage  <= '0;
            alu_stage <= '0;
            done      <= 1'b0;
        end else begin
            case (state)
                vec_op_pkg::st_idle: begin
                    if (instr_valid) begin
                        state     <= vec_op_pkg::st_run;
                        issuing   <= 1'b1;
                        issue_off <= '0;
                    end
                end
                vec_op_pkg::st_run: begin
                    // walk offsets 0..3, one per cycle
                    if (issuing) begin
                        issue_off <= issue_off + 1'b1;
                        if (int'(issue_off) == vec_cfg_pkg::chunks_per_vec - 1) begin
                            issuing <= 1'b0;
                        end
                    end
                    // busy stays up through the done cycle
                    if (done) begin
                        state <= vec_op_pkg::st_idle;
                    end
                end
                default: state <= vec_op_pkg::st_idle;
            endcase
            rd_stage.valid  <= issuing;
            rd_stage.off    <= issue_off;
            // store chunks leave the pipe after the read stage
            alu_stage.valid <= rd_stage.valid & ~is_store;
            alu_stage.off   <= rd_stage.off;
            done            <= last_retire;
        end
    end

    // instruction payload, captured on acceptance only
    always_ff @(posedge clk) begin
        if ((state == vec_op_pkg::st_idle) && instr_valid) begin
            instr_r <= instr;
        end
    end

    // operand reads for alu ops
    assign rd_en_1   = {vec_cfg_pkg::dw_b{issuing & ~is_store}};
    assign rd_en_2   = {vec_cfg_pkg::dw_b{issuing & ~is_store}};
    assign rd_addr_1 = instr_r.vs1;
    assign rd_addr_2 = instr_r.vs2;
    assign rd_off_1  = issue_off;
    assign rd_off_2  = issue_off;

    // store stream reads vs1 through the store copy
    assign st_en    = {vec_cfg_pkg::dw_b{issuing & is_store}};
    assign st_addr  = instr_r.vs1;
    assign st_off   = issue_off;
    assign st_valid = rd_stage.valid & is_store;

    assign alu_opcode = instr_r.opcode;
    assign op_valid   = rd_stage.valid & ~is_store;

    // masked write-back, mask is the same for every chunk
    assign wb_en   = alu_stage.valid ? instr_r.byte_mask : '0;
    assign wb_addr = instr_r.vd;
    assign wb_off  = alu_stage.off;

    // write-back only happens inside an accepted instruction window
    wb_inside_busy: assert property (@(posedge clk) disable iff (reset)
        (|wb_en) |-> busy);

endmodule

// ==== hw/vec_lane_alu.sv ====
`timescale 1ns/1ps

module vec_lane_alu (
    input  logic                                 clk,
    input  logic                                 op_valid,
    input  vec_op_pkg::vec_opcode_e              opcode,
    input  logic [vec_cfg_pkg::data_width-1:0]   a,
    input  logic [vec_cfg_pkg::data_width-1:0]   b,
    output logic [vec_cfg_pkg::data_width-1:0]   result
);

    // combinational lane results before the output register
    logic [vec_cfg_pkg::data_width-1:0] lane_res;

    // each byte lane is computed on its own
    // 8-bit slices keep carries and borrows inside the lane
    always_comb begin
        lane_res = '0;
        for (int i = 0; i < vec_cfg_pkg::dw_b; i++) begin
            case (opcode)
                vec_op_pkg::op_vadd: begin
                    lane_res[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] =
                        a[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] +
                        b[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w];
                end
                vec_op_pkg::op_vsub: begin
                    lane_res[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] =
                        a[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] -
                        b[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w];
                end
                // the logic ops could be done on the full chunk, kept per lane for symmetry
                vec_op_pkg::op_vand: begin
                    lane_res[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] =
                        a[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] &
                        b[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w];
                end
                vec_op_pkg::op_vor: begin
                    lane_res[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] =
                        a[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] |
                        b[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w];
                end
                vec_op_pkg::op_vxor: begin
                    lane_res[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] =
                        a[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] ^
                        b[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w];
                end
                // vstore never reaches the alu
                default: begin
                    lane_res[i*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] = '0;
                end
            endcase
        end
    end

    // result only moves when the sequencer has a live chunk here
    always_ff @(posedge clk) begin
        if (op_valid) begin
            result <= lane_res;
        end
    end

    // the sequencer routes vstore to the store port, never through here
    no_store_in_alu: assert property (@(posedge clk)
        op_valid |-> (opcode != vec_op_pkg::op_vstore));

endmodule

// ==== hw/vec_regfile.sv ====
`timescale 1ns/1ps

module vec_regfile (
    input  logic                                 clk,
    input  logic [vec_cfg_pkg::dw_b-1:0]         rd_en_1,
    input  logic [vec_cfg_pkg::dw_b-1:0]         rd_en_2,
    input  logic [vec_cfg_pkg::dw_b-1:0]         wr_en,
    input  logic [vec_cfg_pkg::dw_b-1:0]         st_en,
    input  logic [vec_cfg_pkg::addr_width-1:0]   rd_addr_1,
    input  logic [vec_cfg_pkg::addr_width-1:0]   rd_addr_2,
    input  logic [vec_cfg_pkg::addr_width-1:0]   wr_addr,
    input  logic [vec_cfg_pkg::addr_width-1:0]   st_addr,
    input  logic [vec_cfg_pkg::off_bits-1:0]     rd_off_1,
    input  logic [vec_cfg_pkg::off_bits-1:0]     rd_off_2,
    input  logic [vec_cfg_pkg::off_bits-1:0]     wr_off,
    input  logic [vec_cfg_pkg::off_bits-1:0]     st_off,
    input  logic [vec_cfg_pkg::data_width-1:0]   wr_data,
    output logic [vec_cfg_pkg::data_width-1:0]   rd_data_1,
    output logic [vec_cfg_pkg::data_width-1:0]   rd_data_2,
    output logic [vec_cfg_pkg::data_width-1:0]   st_data
);

    // operand copy feeds the two alu read ports
    logic [vec_cfg_pkg::data_width-1:0] op_mem [vec_cfg_pkg::rf_depth];
    // store copy feeds the store stream only
    logic [vec_cfg_pkg::data_width-1:0] st_mem [vec_cfg_pkg::rf_depth];

    // flat chunk indices
    logic [vec_cfg_pkg::chunk_idx_w-1:0] rd_idx_1;
    logic [vec_cfg_pkg::chunk_idx_w-1:0] rd_idx_2;
    logic [vec_cfg_pkg::chunk_idx_w-1:0] wr_idx;
    logic [vec_cfg_pkg::chunk_idx_w-1:0] st_idx;

    // port activity strobes
    logic op_upd;
    logic st_upd;

    assign rd_idx_1 = {rd_addr_1, rd_off_1};
    assign rd_idx_2 = {rd_addr_2, rd_off_2};
    assign wr_idx   = {wr_addr, wr_off};
    assign st_idx   = {st_addr, st_off};

    // any byte enable wakes the port
    assign op_upd = (|rd_en_1) | (|rd_en_2) | (|wr_en);
    assign st_upd = (|st_en) | (|wr_en);

    // operand copy, read-before-write on the same edge
    always_ff @(posedge clk) begin
        if (op_upd) begin
            for (int j = 0; j < vec_cfg_pkg::dw_b; j++) begin
                if (wr_en[j]) begin
                    op_mem[wr_idx][j*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] <=
                        wr_data[j*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w];
                end
            end
            rd_data_1 <= op_mem[rd_idx_1];
            rd_data_2 <= op_mem[rd_idx_2];
        end
    end

    // store copy gets the identical byte write
    always_ff @(posedge clk) begin
        if (st_upd) begin
            for (int j = 0; j < vec_cfg_pkg::dw_b; j++) begin
                if (wr_en[j]) begin
                    st_mem[wr_idx][j*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w] <=
                        wr_data[j*vec_cfg_pkg::byte_w +: vec_cfg_pkg::byte_w];
                end
            end
            st_data <= st_mem[st_idx];
        end
    end

    // a chunk read on its own write edge would return the old data
    rd_wr_chunk_apart: assert property (@(posedge clk)
        (|wr_en) |-> ((!(|rd_en_1) || (wr_idx != rd_idx_1)) &&
                      (!(|rd_en_2) || (wr_idx != rd_idx_2))));

endmodule

// ==== hw/vec_op_pkg.sv ====
package vec_op_pkg;

    // vector opcodes
    // all alu ops work on 8-bit elements, add/sub wrap inside the lane
    typedef enum logic [2:0] {
        op_vadd   = 3'd0,
        op_vsub   = 3'd1,
        op_vand   = 3'd2,
        op_vor    = 3'd3,
        op_vxor   = 3'd4,
        op_vstore = 3'd5
    } vec_opcode_e;

    // sequencer states
    typedef enum logic [0:0] {
        st_idle = 1'b0,
        st_run  = 1'b1
    } seq_state_e;

    // one vector instruction, 20 bits
    // vd is the write-back target, vs1 is also the source of vstore
    // byte_mask is applied the same way to every chunk of vd
    typedef struct packed {
        vec_opcode_e                          opcode;
        logic [vec_cfg_pkg::addr_width-1:0]   vd;
        logic [vec_cfg_pkg::addr_width-1:0]   vs1;
        logic [vec_cfg_pkg::addr_width-1:0]   vs2;
        logic [vec_cfg_pkg::dw_b-1:0]         byte_mask;
    } vec_instr_t;

    // host preload of one chunk, 77 bits
    typedef struct packed {
        logic [vec_cfg_pkg::dw_b-1:0]         be;
        logic [vec_cfg_pkg::addr_width-1:0]   addr;
        logic [vec_cfg_pkg::off_bits-1:0]     off;
        logic [vec_cfg_pkg::data_width-1:0]   data;
    } host_wr_t;

endpackage

// ==== hw/vec_cfg_pkg.sv ====
package vec_cfg_pkg;

    // bits in one architectural vector
    localparam int vlen = 256;

    // one chunk is the unit moved per cycle on every port
    localparam int data_width = 64;

    localparam int byte_w = 8;

    // byte lanes per chunk, also the width of every enable bus
    localparam int dw_b = data_width / byte_w;

    localparam int chunks_per_vec = vlen / data_width;

    // eight vector registers
    localparam int addr_width = 3;

    // chunk offset inside one vector
    localparam int off_bits = $clog2(chunks_per_vec);

    // flat chunk index is {addr, off}
    localparam int chunk_idx_w = addr_width + off_bits;

    // chunks held by each copy of the register file
    localparam int rf_depth = chunks_per_vec << addr_width;

endpackage
